/* include/rv_settings.svh */
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

`define RV_RESET_PC      32'h0000_0000  // First fetch address
`define RV_IO_BASE       32'h0000_1000  // Output port from here upwards

`define RAM_DEPTH_WORDS  1024           // Power of two
`define RAM_WAIT_CYCLES  1              // Access cycles with pready low

`endif

/* hw/rv_pkg.sv */
package rv_pkg;

	typedef logic [31:0] word_t;
	typedef logic [31:0] addr_t;     // Byte address
	typedef logic [4:0]  reg_idx_t;
	typedef logic [3:0]  strb_t;     // One bit per byte lane
	typedef logic [2:0]  group_t;    // Instruction group seen by the FSM

	// Instruction groups, decoded in the core from the opcode
	localparam group_t GRP_REG    = 3'd0;  // LUI, AUIPC, OP, OP-IMM
	localparam group_t GRP_JUMP   = 3'd1;  // JAL, JALR
	localparam group_t GRP_BRANCH = 3'd2;
	localparam group_t GRP_LOAD   = 3'd3;
	localparam group_t GRP_STORE  = 3'd4;
	localparam group_t GRP_SYSTEM = 3'd5;  // Also unknown opcodes

	typedef enum logic [2:0] {
		FETCH_SETUP,
		FETCH_ACCESS,
		EXECUTE,
		MEM_SETUP,
		MEM_ACCESS,
		WRITEBACK,
		HALTED
	} ctrl_state_e;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND
	} alu_op_e;

endpackage

/* hw/rv_regfile.sv */
`timescale 1ns/100ps

module rv_regfile (
	input  logic             APB_PCLK,
	input  rv_pkg::reg_idx_t ra0,
	input  rv_pkg::reg_idx_t ra1,
	input  rv_pkg::reg_idx_t wa,
	input  logic             we,
	input  rv_pkg::word_t    wd,
	output rv_pkg::word_t    rd0,
	output rv_pkg::word_t    rd1
);

	rv_pkg::word_t regs [32];

	// x0 is never written, so the mux hides its contents
	assign rd0 = (ra0 == '0) ? '0 : regs[ra0];
	assign rd1 = (ra1 == '0) ? '0 : regs[ra1];

	always_ff @(posedge APB_PCLK) begin
		if (we && wa != '0) begin
			regs[wa] <= wd;
		end
	end

endmodule

/* hw/rv_alu.sv */
`timescale 1ns/100ps

module rv_alu (
	input  rv_pkg::alu_op_e op,
	input  rv_pkg::word_t   a,
	input  rv_pkg::word_t   b,
	output rv_pkg::word_t   y,
	input  logic [2:0]      funct3,
	output logic            take_branch
);

	logic [4:0] shamt;
	logic       lt_s;
	logic       lt_u;

	assign shamt = b[4:0];
	assign lt_s  = $signed(a) < $signed(b);
	assign lt_u  = a < b;

	always_comb begin
		case (op)
			rv_pkg::ALU_SUB:  y = a - b;
			rv_pkg::ALU_SLL:  y = a << shamt;
			rv_pkg::ALU_SLT:  y = {31'b0, lt_s};
			rv_pkg::ALU_SLTU: y = {31'b0, lt_u};
			rv_pkg::ALU_XOR:  y = a ^ b;
			rv_pkg::ALU_SRL:  y = a >> shamt;
			rv_pkg::ALU_SRA:  y = $signed(a) >>> shamt;  // Keeps the sign bit
			rv_pkg::ALU_OR:   y = a | b;
			rv_pkg::ALU_AND:  y = a & b;
			default:          y = a + b;
		endcase
	end

	// Branch decision straight from the operands
	always_comb begin
		case (funct3)
			3'b000:  take_branch = a == b;   // BEQ
			3'b001:  take_branch = a != b;   // BNE
			3'b100:  take_branch = lt_s;     // BLT
			3'b101:  take_branch = !lt_s;    // BGE
			3'b110:  take_branch = lt_u;     // BLTU
			3'b111:  take_branch = !lt_u;    // BGEU
			default: take_branch = 1'b0;
		endcase
	end

endmodule

/* hw/rv_control.sv */
`timescale 1ns/100ps

module rv_control (
	input  logic           APB_PCLK,
	input  logic           APB_PRESETn,
	input  rv_pkg::group_t group,
	input  logic           take_branch,
	input  logic           APB_pready,
	input  logic           APB_perr,
	input  logic           zero_instr,
	output logic           psel,
	output logic           penable,
	output logic           pwrite,
	output logic           load_instr,
	output logic           load_addr_reg,
	output logic           reg_write,
	output logic           pc_write,
	output logic           halted
);

	rv_pkg::ctrl_state_e state;
	rv_pkg::ctrl_state_e next_state;
	logic                mem_group;
	logic                stop;
	logic                run;

	assign mem_group = (group == rv_pkg::GRP_LOAD) || (group == rv_pkg::GRP_STORE);
	assign stop      = zero_instr || (group == rv_pkg::GRP_SYSTEM);
	assign run       = (state == rv_pkg::EXECUTE) && !stop;  // Instruction really executes

	always_comb begin
		next_state = state;
		case (state)
			rv_pkg::FETCH_SETUP: begin
				// Out of reset psel is still low, so the setup cycle comes one later
				if (psel)
					next_state = rv_pkg::FETCH_ACCESS;
			end
			rv_pkg::FETCH_ACCESS: begin
				if (APB_pready)
					next_state = APB_perr ? rv_pkg::HALTED : rv_pkg::EXECUTE;
			end
			rv_pkg::EXECUTE: begin
				if (stop)
					next_state = rv_pkg::HALTED;
				else if (mem_group)
					next_state = rv_pkg::MEM_SETUP;
				else
					next_state = rv_pkg::FETCH_SETUP;
			end
			rv_pkg::MEM_SETUP: next_state = rv_pkg::MEM_ACCESS;
			rv_pkg::MEM_ACCESS: begin
				if (APB_pready) begin
					if (APB_perr)
						next_state = rv_pkg::HALTED;
					else if (group == rv_pkg::GRP_LOAD)
						next_state = rv_pkg::WRITEBACK;
					else
						next_state = rv_pkg::FETCH_SETUP;
				end
			end
			rv_pkg::WRITEBACK: next_state = rv_pkg::FETCH_SETUP;
			default:           next_state = rv_pkg::HALTED;  // HALTED holds until reset
		endcase
	end

	// Bus phase outputs are registered from the next state
	always_ff @(posedge APB_PCLK) begin
		if (!APB_PRESETn) begin
			state   <= rv_pkg::FETCH_SETUP;
			psel    <= 1'b0;
			penable <= 1'b0;
			pwrite  <= 1'b0;
		end else begin
			state   <= next_state;
			psel    <= (next_state == rv_pkg::FETCH_SETUP) ||
			           (next_state == rv_pkg::FETCH_ACCESS) ||
			           (next_state == rv_pkg::MEM_SETUP) ||
			           (next_state == rv_pkg::MEM_ACCESS);
			penable <= (next_state == rv_pkg::FETCH_ACCESS) ||
			           (next_state == rv_pkg::MEM_ACCESS);
			pwrite  <= ((next_state == rv_pkg::MEM_SETUP) ||
			            (next_state == rv_pkg::MEM_ACCESS)) &&
			           (group == rv_pkg::GRP_STORE);
		end
	end

	assign load_instr    = (state == rv_pkg::FETCH_ACCESS) && APB_pready;
	assign load_addr_reg = run && mem_group;
	assign reg_write     = (run && (group == rv_pkg::GRP_REG || group == rv_pkg::GRP_JUMP)) ||
	                       (state == rv_pkg::WRITEBACK);
	// PC already moved on by 4 at fetch, only redirects load it here
	assign pc_write      = run && ((group == rv_pkg::GRP_JUMP) ||
	                               (group == rv_pkg::GRP_BRANCH && take_branch));
	assign halted        = state == rv_pkg::HALTED;

endmodule

/* hw/rv_core.sv */
`timescale 1ns/100ps
`include "rv_settings.svh"

module rv_core (
	input  logic          APB_PCLK,
	input  logic          APB_PRESETn,
	output rv_pkg::addr_t APB_paddr,
	output rv_pkg::word_t APB_pwdata,
	input  rv_pkg::word_t APB_prdata,
	output logic          APB_psel,
	output logic          APB_penable,
	output logic          APB_pwrite,
	output rv_pkg::strb_t APB_pstrb,
	input  logic          APB_pready,
	input  logic          APB_perr,
	output logic          halted
);

	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_IMM    = 7'b0010011;
	localparam logic [6:0] OPC_REG    = 7'b0110011;

	rv_pkg::addr_t   pc;         // Already points past the instruction in EXECUTE
	rv_pkg::addr_t   inst_pc;
	rv_pkg::word_t   instr_q;
	rv_pkg::addr_t   addr_q;
	rv_pkg::word_t   data_q;     // Store data out, load data in
	logic            data_phase;
	logic [6:0]      opcode;
	logic [2:0]      funct3;
	rv_pkg::group_t  group;
	rv_pkg::word_t   imm_i;
	rv_pkg::word_t   imm_s;
	rv_pkg::word_t   imm_b;
	rv_pkg::word_t   imm_u;
	rv_pkg::word_t   imm_j;
	rv_pkg::word_t   rd0;
	rv_pkg::word_t   rd1;
	rv_pkg::word_t   alu_a;
	rv_pkg::word_t   alu_b;
	rv_pkg::word_t   alu_y;
	rv_pkg::alu_op_e alu_op;
	logic            take_branch;
	rv_pkg::addr_t   pc_target;
	rv_pkg::word_t   lane;
	rv_pkg::word_t   load_ext;
	rv_pkg::word_t   wb_data;
	rv_pkg::strb_t   strb;
	logic            load_instr;
	logic            load_addr_reg;
	logic            reg_write;
	logic            pc_write;

	assign opcode  = instr_q[6:0];
	assign funct3  = instr_q[14:12];
	assign inst_pc = pc - 32'd4;

	assign imm_i = {{20{instr_q[31]}}, instr_q[31:20]};
	assign imm_s = {{20{instr_q[31]}}, instr_q[31:25], instr_q[11:7]};
	assign imm_b = {{19{instr_q[31]}}, instr_q[31], instr_q[7], instr_q[30:25],
	                instr_q[11:8], 1'b0};
	assign imm_u = {instr_q[31:12], 12'b0};
	assign imm_j = {{11{instr_q[31]}}, instr_q[31], instr_q[19:12], instr_q[20],
	                instr_q[30:21], 1'b0};

	always_comb begin
		case (opcode)
			OPC_LUI, OPC_AUIPC, OPC_IMM, OPC_REG: group = rv_pkg::GRP_REG;
			OPC_JAL, OPC_JALR:                    group = rv_pkg::GRP_JUMP;
			OPC_BRANCH:                           group = rv_pkg::GRP_BRANCH;
			OPC_LOAD:                             group = rv_pkg::GRP_LOAD;
			OPC_STORE:                            group = rv_pkg::GRP_STORE;
			default:                              group = rv_pkg::GRP_SYSTEM;
		endcase
	end

	// ALU operands and operation
	always_comb begin
		alu_a  = (opcode == OPC_LUI) ? '0 : (opcode == OPC_AUIPC) ? inst_pc : rd0;
		alu_b  = imm_i;
		alu_op = rv_pkg::ALU_ADD;
		if (opcode == OPC_REG || opcode == OPC_BRANCH)
			alu_b = rd1;
		else if (opcode == OPC_STORE)
			alu_b = imm_s;
		else if (opcode == OPC_LUI || opcode == OPC_AUIPC)
			alu_b = imm_u;
		if (opcode == OPC_REG || opcode == OPC_IMM) begin
			case (funct3)
				3'b000:  alu_op = (opcode == OPC_REG && instr_q[30]) ? rv_pkg::ALU_SUB
				                                                     : rv_pkg::ALU_ADD;
				3'b001:  alu_op = rv_pkg::ALU_SLL;
				3'b010:  alu_op = rv_pkg::ALU_SLT;
				3'b011:  alu_op = rv_pkg::ALU_SLTU;
				3'b100:  alu_op = rv_pkg::ALU_XOR;
				3'b101:  alu_op = instr_q[30] ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
				3'b110:  alu_op = rv_pkg::ALU_OR;
				default: alu_op = rv_pkg::ALU_AND;
			endcase
		end
	end

	assign pc_target = (opcode == OPC_JAL)  ? inst_pc + imm_j :
	                   (opcode == OPC_JALR) ? (alu_y & ~32'h1) :
	                                          inst_pc + imm_b;

	// Load lane select and extension
	assign lane = data_q >> {addr_q[1:0], 3'b000};
	always_comb begin
		case (funct3)
			3'b000:  load_ext = {{24{lane[7]}}, lane[7:0]};
			3'b001:  load_ext = {{16{lane[15]}}, lane[15:0]};
			3'b100:  load_ext = {24'b0, lane[7:0]};
			3'b101:  load_ext = {16'b0, lane[15:0]};
			default: load_ext = lane;
		endcase
	end

	assign wb_data = (opcode == OPC_LOAD) ? load_ext :
	                 (opcode == OPC_JAL || opcode == OPC_JALR) ? pc : alu_y;  // Link is pc

	always_comb begin
		case (funct3[1:0])
			2'b00:   strb = 4'b0001 << addr_q[1:0];
			2'b01:   strb = 4'b0011 << {addr_q[1], 1'b0};
			default: strb = 4'b1111;
		endcase
	end

	assign APB_pstrb  = APB_pwrite ? strb : 4'b1111;
	assign APB_paddr  = data_phase ? addr_q : pc;
	assign APB_pwdata = data_q;

	always_ff @(posedge APB_PCLK) begin
		if (!APB_PRESETn) begin
			pc         <= `RV_RESET_PC;
			data_phase <= 1'b0;
		end else begin
			if (load_instr)
				pc <= pc + 32'd4;
			else if (pc_write)
				pc <= pc_target;
			if (load_addr_reg)
				data_phase <= 1'b1;
			else if (APB_penable && APB_pready)
				data_phase <= 1'b0;  // Back to fetch addressing
		end
	end

	always_ff @(posedge APB_PCLK) begin
		if (load_instr)
			instr_q <= APB_prdata;
		if (load_addr_reg) begin
			addr_q <= alu_y;
			data_q <= rd1 << {alu_y[1:0], 3'b000};  // Store data onto its byte lane
		end else if (data_phase && APB_penable && APB_pready && !APB_pwrite) begin
			data_q <= APB_prdata;
		end
	end

	rv_control rv_control_i (
		.APB_PCLK      (APB_PCLK),
		.APB_PRESETn   (APB_PRESETn),
		.group         (group),
		.take_branch   (take_branch),
		.APB_pready    (APB_pready),
		.APB_perr      (APB_perr),
		.zero_instr    (instr_q == '0),
		.psel          (APB_psel),
		.penable       (APB_penable),
		.pwrite        (APB_pwrite),
		.load_instr    (load_instr),
		.load_addr_reg (load_addr_reg),
		.reg_write     (reg_write),
		.pc_write      (pc_write),
		.halted        (halted)
	);

	rv_alu rv_alu_i (
		.op          (alu_op),
		.a           (alu_a),
		.b           (alu_b),
		.y           (alu_y),
		.funct3      (funct3),
		.take_branch (take_branch)
	);

	rv_regfile rv_regfile_i (
		.APB_PCLK (APB_PCLK),
		.ra0      (instr_q[19:15]),
		.ra1      (instr_q[24:20]),
		.wa       (instr_q[11:7]),
		.we       (reg_write),
		.wd       (wb_data),
		.rd0      (rd0),
		.rd1      (rd1)
	);

endmodule

/* hw/apb_ram.sv */
`timescale 1ns/100ps
`include "rv_settings.svh"

module apb_ram #(
	parameter int DEPTH = `RAM_DEPTH_WORDS,
	parameter int WAIT  = `RAM_WAIT_CYCLES
) (
	input  logic          APB_PCLK,
	input  logic          APB_PRESETn,
	input  rv_pkg::addr_t paddr,
	input  rv_pkg::word_t pwdata,
	input  rv_pkg::strb_t pstrb,
	input  logic          psel,
	input  logic          penable,
	input  logic          pwrite,
	output rv_pkg::word_t prdata,
	output logic          pready,
	input  logic          load_we,
	input  rv_pkg::addr_t load_addr,  // Byte address
	input  rv_pkg::word_t load_data
);

	localparam int AW = $clog2(DEPTH);
	localparam int CW = (WAIT > 0) ? $clog2(WAIT + 1) : 1;

	rv_pkg::word_t mem [DEPTH];
	logic [CW-1:0] wait_cnt;
	logic [AW-1:0] idx;
	logic [AW-1:0] load_idx;
	logic          access_done;

	assign idx         = paddr[AW+1:2];
	assign load_idx    = load_addr[AW+1:2];
	assign pready      = wait_cnt == CW'(WAIT);
	assign access_done = psel && penable && pready;
	assign prdata      = mem[idx];

	// Counts access cycles while pready is held low
	always_ff @(posedge APB_PCLK) begin
		if (!APB_PRESETn)
			wait_cnt <= '0;
		else if (access_done || !(psel && penable))
			wait_cnt <= '0;
		else
			wait_cnt <= wait_cnt + 1'b1;
	end

	always_ff @(posedge APB_PCLK) begin
		if (!APB_PRESETn) begin
			if (load_we)
				mem[load_idx] <= load_data;  // Boot loader only in reset
		end else if (access_done && pwrite) begin
			for (int i = 0; i < 4; i++) begin
				if (pstrb[i])
					mem[idx][8*i +: 8] <= pwdata[8*i +: 8];
			end
		end
	end

endmodule

/* hw/apb_periph.sv */
`timescale 1ns/100ps
`include "rv_settings.svh"

module apb_periph (
	input  logic          APB_PCLK,
	input  logic          APB_PRESETn,
	input  rv_pkg::addr_t APB_paddr,
	input  rv_pkg::word_t APB_pwdata,
	input  logic          APB_psel,
	input  logic          APB_penable,
	input  logic          APB_pwrite,
	output rv_pkg::word_t APB_prdata,
	output logic          APB_pready,
	output logic          APB_perr,
	output logic          ram_psel,
	input  rv_pkg::word_t ram_prdata,
	input  logic          ram_pready,
	output logic          out_valid,
	output rv_pkg::word_t out_data
);

	localparam rv_pkg::addr_t RAM_TOP = rv_pkg::addr_t'(`RAM_DEPTH_WORDS * 4);

	logic io_sel;
	logic range_err;
	logic io_write;

	assign io_sel    = APB_paddr >= `RV_IO_BASE;
	assign range_err = !io_sel && (APB_paddr >= RAM_TOP);  // Hole between RAM and I/O

	assign ram_psel   = APB_psel && !io_sel && !range_err;
	assign APB_prdata = ram_psel ? ram_prdata : '0;
	assign APB_pready = ram_psel ? ram_pready : 1'b1;  // I/O and hole answer at once
	assign APB_perr   = APB_psel && APB_penable && range_err;

	assign io_write = APB_psel && APB_penable && APB_pwrite && io_sel;

	always_ff @(posedge APB_PCLK) begin
		if (!APB_PRESETn)
			out_valid <= 1'b0;
		else
			out_valid <= io_write;  // One cycle after completion
	end

	always_ff @(posedge APB_PCLK) begin
		if (io_write)
			out_data <= APB_pwdata;
	end

endmodule

/* hw/rv_system.sv */
`timescale 1ns/100ps

module rv_system (
	input  logic          APB_PCLK,
	input  logic          APB_PRESETn,
	input  logic          load_we,
	input  rv_pkg::addr_t load_addr,
	input  rv_pkg::word_t load_data,
	output logic          out_valid,
	output rv_pkg::word_t out_data,
	output logic          halted
);

	rv_pkg::addr_t paddr;
	rv_pkg::word_t pwdata;
	rv_pkg::word_t prdata;
	rv_pkg::strb_t pstrb;
	logic          psel;
	logic          penable;
	logic          pwrite;
	logic          pready;
	logic          perr;
	logic          ram_psel;
	rv_pkg::word_t ram_prdata;
	logic          ram_pready;

	rv_core rv_core_i (
		.APB_PCLK    (APB_PCLK),
		.APB_PRESETn (APB_PRESETn),
		.APB_paddr   (paddr),
		.APB_pwdata  (pwdata),
		.APB_prdata  (prdata),
		.APB_psel    (psel),
		.APB_penable (penable),
		.APB_pwrite  (pwrite),
		.APB_pstrb   (pstrb),
		.APB_pready  (pready),
		.APB_perr    (perr),
		.halted      (halted)
	);

	apb_periph apb_periph_i (
		.APB_PCLK    (APB_PCLK),
		.APB_PRESETn (APB_PRESETn),
		.APB_paddr   (paddr),
		.APB_pwdata  (pwdata),
		.APB_psel    (psel),
		.APB_penable (penable),
		.APB_pwrite  (pwrite),
		.APB_prdata  (prdata),
		.APB_pready  (pready),
		.APB_perr    (perr),
		.ram_psel    (ram_psel),
		.ram_prdata  (ram_prdata),
		.ram_pready  (ram_pready),
		.out_valid   (out_valid),
		.out_data    (out_data)
	);

	apb_ram apb_ram_i (
		.APB_PCLK    (APB_PCLK),
		.APB_PRESETn (APB_PRESETn),
		.paddr       (paddr),
		.pwdata      (pwdata),
		.pstrb       (pstrb),
		.psel        (ram_psel),
		.penable     (penable),
		.pwrite      (pwrite),
		.prdata      (ram_prdata),
		.pready      (ram_pready),
		.load_we     (load_we),
		.load_addr   (load_addr),
		.load_data   (load_data)
	);

endmodule

/* testbench/tb_clock.sv */
`timescale 1ns/100ps

module tb_clock (
	input  logic hold,
	output logic APB_PCLK,
	output logic APB_PRESETn
);

	logic clk   = 1'b0;
	logic rst_n = 1'b0;
	int   held  = 0;  // Cycles since hold dropped

	always #5 clk = ~clk;  // 10 ns period

	// Reset stays low while hold is high and for 16 cycles after that
	always @(posedge clk) begin
		if (hold)
			held <= 0;
		else if (held < 16)
			held <= held + 1;
		rst_n <= !hold && (held >= 16);
	end

	assign APB_PCLK    = clk;
	assign APB_PRESETn = rst_n;

endmodule

/* testbench/tb_rv_system.sv */
`timescale 1ns/100ps

module tb_rv_system;

	localparam int N_TESTS   = 8;
	localparam int N_WORDS   = 16;
	localparam int N_OUT     = 4;
	localparam int MAX_CYCLES = N_TESTS * (N_WORDS * 20 + 40);  // Loading and reset included

	localparam int OPC_LOAD  = 'h03;
	localparam int OPC_IMM   = 'h13;
	localparam int OPC_AUIPC = 'h17;
	localparam int OPC_LUI   = 'h37;
	localparam int OPC_JALR  = 'h67;
	localparam int IO        = 31;  // Register holding the output address

	logic          APB_PCLK;
	logic          APB_PRESETn;
	logic          hold      = 1'b1;
	logic          load_we   = 1'b0;
	rv_pkg::addr_t load_addr = '0;
	rv_pkg::word_t load_data = '0;
	logic          out_valid;
	rv_pkg::word_t out_data;
	logic          halted;

	string         names [N_TESTS];
	rv_pkg::word_t code [N_TESTS][N_WORDS];
	rv_pkg::word_t exp_out [N_TESTS][N_OUT];
	int            exp_count [N_TESTS];
	rv_pkg::word_t seen [$];   // out_data of the running test
	int            errors;
	int            passed;
	int            failed;

	tb_clock tb_clock_i (
		.hold        (hold),
		.APB_PCLK    (APB_PCLK),
		.APB_PRESETn (APB_PRESETn)
	);

	rv_system rv_system_i (
		.APB_PCLK    (APB_PCLK),
		.APB_PRESETn (APB_PRESETn),
		.load_we     (load_we),
		.load_addr   (load_addr),
		.load_data   (load_data),
		.out_valid   (out_valid),
		.out_data    (out_data),
		.halted      (halted)
	);

	// RV32I instruction formats
	function automatic rv_pkg::word_t r_type(int f7, int f3, int rd, int rs1, int rs2);
		return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
	endfunction

	function automatic rv_pkg::word_t i_type(int opc, int f3, int rd, int rs1, int imm);
		return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
	endfunction

	function automatic rv_pkg::word_t s_type(int f3, int rs2, int rs1, int imm);
		return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'h23};
	endfunction

	function automatic rv_pkg::word_t b_type(int f3, int rs1, int rs2, int imm);
		return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
	endfunction

	function automatic rv_pkg::word_t u_type(int opc, int rd, int imm);
		return {imm[19:0], rd[4:0], opc[6:0]};
	endfunction

	function automatic rv_pkg::word_t j_type(int rd, int imm);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
	endfunction

	function automatic rv_pkg::word_t addi(int rd, int rs1, int imm);
		return i_type(OPC_IMM, 0, rd, rs1, imm);
	endfunction

	function automatic rv_pkg::word_t out_sw(int rs2);
		return s_type(2, rs2, IO, 0);  // SW to the output port
	endfunction

	task automatic fill_table();
		names[0] = "add_sub_xor_or";
		code[0] = '{u_type(OPC_LUI, IO, 1), addi(1, 0, -7), addi(2, 0, 12),
		            r_type(0, 0, 3, 1, 2), out_sw(3), r_type('h20, 0, 4, 1, 2), out_sw(4),
		            r_type(0, 4, 5, 1, 2), out_sw(5), r_type(0, 6, 6, 1, 2), out_sw(6),
		            0, 0, 0, 0, 0};
		exp_out[0] = '{32'h0000_0005, 32'hFFFF_FFED, 32'hFFFF_FFF5, 32'hFFFF_FFFD};
		exp_count[0] = 4;
		names[1] = "and_shifts";
		code[1] = '{u_type(OPC_LUI, IO, 1), addi(1, 0, -7), addi(2, 0, 12),
		            r_type(0, 7, 3, 1, 2), out_sw(3), addi(4, 0, 3), r_type(0, 1, 5, 2, 4),
		            out_sw(5), r_type(0, 5, 6, 1, 4), out_sw(6),
		            i_type(OPC_IMM, 5, 7, 1, 'h402), out_sw(7), 0, 0, 0, 0};  // SRAI by 2
		exp_out[1] = '{32'h0000_0008, 32'h0000_0060, 32'h1FFF_FFFF, 32'hFFFF_FFFE};
		exp_count[1] = 4;
		names[2] = "compare_upper";
		code[2] = '{u_type(OPC_LUI, IO, 1), u_type(OPC_LUI, 1, 'h80000), addi(2, 1, -1),
		            r_type(0, 2, 3, 1, 2), r_type(0, 3, 4, 1, 2), out_sw(3), out_sw(4),
		            u_type(OPC_LUI, 5, 'h12345), out_sw(5),
		            u_type(OPC_AUIPC, 6, 'h10), out_sw(6), 0, 0, 0, 0, 0};  // AUIPC at 0x24
		exp_out[2] = '{32'h0000_0001, 32'h0000_0000, 32'h1234_5000, 32'h0001_0024};
		exp_count[2] = 4;
		names[3] = "loop_jumps";
		code[3] = '{u_type(OPC_LUI, IO, 1), addi(1, 0, 5), addi(2, 0, 0),
		            r_type(0, 0, 2, 2, 1), addi(1, 1, -1), b_type(1, 1, 0, -8),
		            out_sw(2), j_type(3, 12), out_sw(3), 0,
		            addi(4, 0, 77), out_sw(4), i_type(OPC_JALR, 0, 0, 3, 0), 0, 0, 0};
		exp_out[3] = '{32'd15, 32'd77, 32'd32, 32'd0};  // Link of the JAL at 0x1c
		exp_count[3] = 3;
		names[4] = "mem_bytes";
		code[4] = '{u_type(OPC_LUI, IO, 1), addi(10, 0, 'h100), u_type(OPC_LUI, 1, 'h12345),
		            addi(1, 1, 'h678), s_type(2, 1, 10, 0), addi(2, 0, -128),
		            s_type(0, 2, 10, 1), addi(3, 0, -2), s_type(1, 3, 10, 2),
		            i_type(OPC_LOAD, 2, 4, 10, 0), out_sw(4), i_type(OPC_LOAD, 0, 5, 10, 1),
		            out_sw(5), i_type(OPC_LOAD, 4, 6, 10, 1), out_sw(6), 0};
		exp_out[4] = '{32'hFFFE_8078, 32'hFFFF_FF80, 32'h0000_0080, 32'h0};
		exp_count[4] = 3;
		names[5] = "mem_halves";
		code[5] = '{u_type(OPC_LUI, IO, 1), addi(10, 0, 'h100), u_type(OPC_LUI, 1, 'h80007),
		            addi(1, 1, 'h7ff), s_type(2, 1, 10, 0), i_type(OPC_LOAD, 1, 2, 10, 2),
		            out_sw(2), i_type(OPC_LOAD, 5, 3, 10, 2), out_sw(3),
		            i_type(OPC_LOAD, 1, 4, 10, 0), out_sw(4), i_type(OPC_LOAD, 4, 5, 10, 0),
		            out_sw(5), 0, 0, 0};
		exp_out[5] = '{32'hFFFF_8000, 32'h0000_8000, 32'h0000_77FF, 32'h0000_00FF};
		exp_count[5] = 4;
		names[6] = "halt_zero";
		code[6] = '{u_type(OPC_LUI, IO, 1), addi(1, 0, 42), out_sw(1), 0, out_sw(1), out_sw(1),
		            0, 0, 0, 0, 0, 0, 0, 0, 0, 0};
		exp_out[6] = '{32'd42, 32'd0, 32'd0, 32'd0};
		exp_count[6] = 1;
		names[7] = "halt_system";
		code[7] = '{u_type(OPC_LUI, IO, 1), addi(1, 0, 9), out_sw(1), 32'h0000_0073,
		            out_sw(1), out_sw(1), 0, 0, 0, 0, 0, 0, 0, 0, 0, 0};  // ECALL stops it
		exp_out[7] = '{32'd9, 32'd0, 32'd0, 32'd0};
		exp_count[7] = 1;
	endtask

	task automatic check(input string name, input string what, input logic [31:0] expected,
	                     input logic [31:0] actual);
		if (expected !== actual) begin
			$display("Error %s %s: expected %08h, actual %08h", name, what, expected, actual);
			errors++;
		end
	endtask

	task automatic run_test(input int t);
		seen.delete();
		errors = 0;
		@(posedge APB_PCLK);
		hold <= 1'b1;
		@(posedge APB_PCLK);  // Reset is low from this edge on
		for (int i = 0; i < N_WORDS; i++) begin
			load_we   <= 1'b1;
			load_addr <= 32'(i * 4);
			load_data <= code[t][i];
			@(posedge APB_PCLK);
		end
		load_we <= 1'b0;
		hold    <= 1'b0;
		@(negedge APB_PCLK);
		while (!APB_PRESETn)
			@(negedge APB_PCLK);
		do begin
			@(negedge APB_PCLK);
			if (out_valid)
				seen.push_back(out_data);
		end while (!halted);
		check(names[t], "output count", exp_count[t], seen.size());
		for (int i = 0; i < N_OUT; i++) begin
			if (i < exp_count[t] && i < seen.size())
				check(names[t], $sformatf("output %0d", i), exp_out[t][i], seen[i]);
		end
		if (errors == 0)
			passed++;
		else
			failed++;
		$display("Test %-14s %s, %0d outputs", names[t], (errors == 0) ? "ok" : "failed",
		         seen.size());
	endtask

	// Watchdog for a core that never halts
	initial begin
		repeat (MAX_CYCLES) @(posedge APB_PCLK);
		$display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
		$display(">>> FAIL");
		$finish;
	end

	initial begin
		passed = 0;
		failed = 0;
		fill_table();
		for (int t = 0; t < N_TESTS; t++)
			run_test(t);
		$display("Summary: %0d tests passed, %0d tests failed", passed, failed);
		if (failed == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

/* list.f */
+incdir+include
hw/rv_pkg.sv
hw/rv_regfile.sv
hw/rv_alu.sv
hw/rv_control.sv
hw/rv_core.sv
hw/apb_ram.sv
hw/apb_periph.sv
hw/rv_system.sv
testbench/tb_clock.sv
testbench/tb_rv_system.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_rv_system
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  := >>> PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)
	@out="$$(./$(OBJ_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
